// File: Bender.yml
package:
  name: arrow_draw

sources:
  - arrow_pkg.sv
  - glyph_picker.sv
  - draw_sequencer.sv
  - stroke_plotter.sv
  - arrow_draw_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - arrow_draw_tb.sv

// File: arrow_draw_model.svh
// reference model of the arrow plotter, included inside the testbench module

// testbench copies of the tip pixel and the generator reset value
localparam int ref_origin_x = 79;
localparam int ref_origin_y = 63;
localparam logic [3:0] lfsr_reset_value = 4'b1110;

// shift up, new bit 0 from bits 2 and 3
function automatic logic [3:0] lfsr_advance(input logic [3:0] r);
	return {r[2:0], r[2] ^ r[3]};
endfunction

// 0..2 up, 3..5 down, 6..8 left, rest right
function automatic logic [1:0] glyph_from_lfsr(input logic [3:0] r);
	if (r <= 4'd2)
		return 2'd0;
	else if (r <= 4'd5)
		return 2'd1;
	else if (r <= 4'd8)
		return 2'd2;
	return 2'd3;
endfunction

function automatic logic [2:0] colour_for_glyph(input logic [1:0] g, input logic erase);
	if (erase)
		return 3'd0;  // black
	case (g)
		2'd0: return 3'd1;
		2'd1: return 3'd2;
		2'd2: return 3'd4;
		default: return 3'd3;
	endcase
endfunction

function automatic int stroke_dx(input logic [1:0] g, input int s);
	case (g)
		2'd0, 2'd1: return (s == 0) ? 0 : ((s == 1) ? 1 : -1);
		2'd2: return 1;
		default: return -1;
	endcase
endfunction

function automatic int stroke_dy(input logic [1:0] g, input int s);
	case (g)
		2'd0: return 1;
		2'd1: return -1;
		default: return (s == 0) ? 0 : ((s == 1) ? -1 : 1);
	endcase
endfunction

// pixel 0..15 of a glyph packed as {x, y}
function automatic logic [14:0] arrow_pixel(input logic [1:0] g, input int idx);
	int s;
	int k;
	int px;
	int py;
	if (idx < 8)
	begin
		s = 0;
		k = idx;
	end
	else if (idx < 12)
	begin
		s = 1;
		k = idx - 8;
	end
	else
	begin
		s = 2;
		k = idx - 12;
	end
	px = ref_origin_x + k * stroke_dx(g, s);
	py = ref_origin_y + k * stroke_dy(g, s);
	return {px[7:0], py[6:0]};
endfunction

// File: arrow_draw_tb.sv
`timescale 1ns/100ps
`default_nettype none

module arrow_draw_tb;

	localparam int pixel_period   = 5;
	localparam int reset_cycles   = 16;
	localparam int num_requests   = 12;
	localparam int timeout_cycles = reset_cycles + num_requests * (16 * pixel_period + 40);

	logic       clk = 1'b0;
	logic       reset_n;
	logic       request;
	logic       clear;
	wire  [7:0] x;
	wire  [6:0] y;
	wire  [2:0] colour;
	wire        plot;
	wire  [1:0] glyph;
	wire        busy;
	wire        done;

	integer      seed;
	logic  [3:0] lfsr_model;
	logic        request_prev;   // request level the DUT saw at the last edge
	logic        busy_seen;      // busy at the last falling edge
	logic        busy_prev;
	logic  [1:0] glyph_q[$];     // glyphs accepted but not yet started
	logic  [2:0] colour_q[$];
	logic        in_glyph;
	logic  [1:0] cur_glyph;
	logic  [2:0] cur_colour;
	logic [14:0] pixel;
	int          pixel_count;
	int          cycle;
	int          last_plot_cycle;
	int          accepted;
	int          done_count;
	int          value_errors;
	int          other_errors;
	int          gap;

	`include "arrow_draw_model.svh"

	arrow_draw_top #(
		.pixel_period (pixel_period)
	) arrow_draw_top_i
	(
		.clk     (clk),
		.reset_n (reset_n),
		.request (request),
		.clear   (clear),
		.x       (x),
		.y       (y),
		.colour  (colour),
		.plot    (plot),
		.glyph   (glyph),
		.busy    (busy),
		.done    (done)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR %0t %s: got %0d expected %0d", $time, name, actual, expected);
			value_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("time %0t: %s", $time, msg);
		other_errors++;
	endtask

	initial
	begin
		forever
			#2 clk = ~clk;
	end

	// accept rule of the picker with ready taken as not busy
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			lfsr_model   = lfsr_reset_value;
			request_prev = 1'b0;
		end
		else
		begin
			if (request && !request_prev && !busy_seen)
			begin
				glyph_q.push_back(glyph_from_lfsr(lfsr_model));
				colour_q.push_back(colour_for_glyph(glyph_from_lfsr(lfsr_model), clear));
				accepted++;
			end
			request_prev = request;
			lfsr_model   = lfsr_advance(lfsr_model);
		end
	end

	// checker samples at the falling edge where outputs are stable
	always @(negedge clk)
	begin
		cycle++;
		busy_prev = busy_seen;
		busy_seen = busy;
		if (busy === 1'b1 && busy_prev !== 1'b1)
		begin
			if (glyph_q.size() == 0)
				report_failure("busy rose without an accepted request");
			else
			begin
				cur_glyph       = glyph_q.pop_front();
				cur_colour      = colour_q.pop_front();
				in_glyph        = 1'b1;
				pixel_count     = 0;
				last_plot_cycle = cycle;  // first plot one period after busy
				check_value("glyph", glyph, cur_glyph);
			end
		end
		if (plot === 1'b1)
		begin
			if (!in_glyph)
				report_failure("plot pulse with no glyph in progress");
			else if (pixel_count >= 16)
				report_failure("more than 16 plots for one glyph");
			else
			begin
				pixel = arrow_pixel(cur_glyph, pixel_count);
				check_value("glyph", glyph, cur_glyph);  // held for the whole glyph
				check_value("x", x, pixel[14:7]);
				check_value("y", y, pixel[6:0]);
				check_value("colour", colour, cur_colour);
				check_value("plot spacing", cycle - last_plot_cycle, pixel_period);
				last_plot_cycle = cycle;
				pixel_count++;
			end
		end
		if (done === 1'b1)
		begin
			if (!in_glyph)
				report_failure("done pulse with no glyph in progress");
			else
			begin
				check_value("plot count", pixel_count, 16);
				check_value("busy", busy, 1'b0);  // falls with done
				in_glyph = 1'b0;
				done_count++;
			end
		end
	end

	initial
	begin
		seed         = 81987;
		reset_n      = 1'b0;
		request      = 1'b0;
		clear        = 1'b0;
		busy_seen    = 1'b0;
		in_glyph     = 1'b0;
		cycle        = 0;
		accepted     = 0;
		done_count   = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (reset_cycles) @(negedge clk);
		reset_n = 1'b1;

		// quiet before the first request
		repeat (4) @(negedge clk);
		check_value("plot", plot, 1'b0);
		check_value("busy", busy, 1'b0);
		check_value("done", done, 1'b0);

		for (int i = 0; i < num_requests; i++)
		begin
			gap = 2 + ($random(seed) & 7);
			repeat (gap) @(negedge clk);
			clear   = (($random(seed) & 3) == 0) || (i == 2);
			request = 1'b1;
			repeat (2) @(negedge clk);
			request = 1'b0;
			clear   = 1'b0;
			while (busy !== 1'b1)
				@(negedge clk);
			// an edge while drawing has to be dropped
			if (($random(seed) & 1) || (i == 3))
			begin
				repeat (1 + ($random(seed) & 15)) @(negedge clk);
				request = 1'b1;
				@(negedge clk);
				request = 1'b0;
			end
			while (done !== 1'b1)
				@(negedge clk);
			@(negedge clk);
		end

		repeat (20) @(negedge clk);
		if (glyph_q.size() != 0 || in_glyph)
			report_failure("a glyph was accepted but never finished");
		check_value("done count", done_count, accepted);

		$display("errors: %0d value, %0d other, %0d glyphs drawn",
			value_errors, other_errors, done_count);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", timeout_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: arrow_draw_top.sv
`timescale 1ns/100ps
`default_nettype none

module arrow_draw_top
	import arrow_pkg::*;
#(
	parameter int pixel_period = 3125000  // clocks per plotted pixel
)
(
	input  wire           clk,
	input  wire           reset_n,
	input  wire           request,
	input  wire           clear,
	output wire coord_x_t x,
	output wire coord_y_t y,
	output wire colour_t  colour,
	output wire           plot,
	output wire glyph_t   glyph,
	output wire           busy,
	output wire           done
);

	wire          ready;
	wire          start;
	wire colour_t pick_colour;   // glyph colour or black
	wire          step_valid;
	wire stroke_t stroke;
	wire step_t   step;

	// picks the glyph and colour on a request edge
	glyph_picker glyph_picker_i
	(
		.clk     (clk),
		.reset_n (reset_n),
		.request (request),
		.clear   (clear),
		.ready   (ready),
		.start   (start),
		.glyph   (glyph),
		.colour  (pick_colour)
	);

	// paces the 16 steps of one glyph
	draw_sequencer #(
		.pixel_period (pixel_period)
	) draw_sequencer_i
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.ready      (ready),
		.busy       (busy),
		.done       (done),
		.step_valid (step_valid),
		.stroke     (stroke),
		.step       (step)
	);

	// step to screen pixel
	stroke_plotter stroke_plotter_i
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.step_valid (step_valid),
		.stroke     (stroke),
		.step       (step),
		.glyph      (glyph),
		.colour_in  (pick_colour),
		.x          (x),
		.y          (y),
		.colour     (colour),
		.plot       (plot)
	);

endmodule

`default_nettype wire

// File: arrow_pkg.sv
`default_nettype none

package arrow_pkg;

	// raster is 160 x 120
	typedef logic [7:0] coord_x_t;   // pixel column
	typedef logic [6:0] coord_y_t;   // pixel row
	typedef logic [2:0] colour_t;    // one bit each of r g b

	typedef logic [3:0] lfsr_t;      // random generator state
	typedef logic [1:0] stroke_t;    // 0 is the shaft, 1 and 2 the head
	typedef logic [2:0] step_t;      // pixel index inside a stroke

	// one axis of a step vector, holds -1 0 or +1
	typedef logic signed [1:0] dir_t;

	typedef enum logic [1:0]
	{
		glyph_up    = 2'd0,
		glyph_down  = 2'd1,
		glyph_left  = 2'd2,
		glyph_right = 2'd3
	} glyph_t;

	// every glyph grows out of this tip pixel
	localparam coord_x_t origin_x = 8'd79;
	localparam coord_y_t origin_y = 7'd63;

	localparam int shaft_len = 8;  // pixels in stroke 0
	localparam int head_len  = 4;  // pixels in strokes 1 and 2

	localparam stroke_t last_stroke = 2'd2;

	// bit 0 comes up low, bits 1 to 3 come up high
	localparam lfsr_t lfsr_seed = 4'b1110;

	// step vectors, first index glyph, second index stroke
	localparam dir_t dir_x [4][3] = '{
		'{ 2'sd0,  2'sd1, -2'sd1},  // up
		'{ 2'sd0,  2'sd1, -2'sd1},  // down
		'{ 2'sd1,  2'sd1,  2'sd1},  // left
		'{-2'sd1, -2'sd1, -2'sd1}   // right
	};

	localparam dir_t dir_y [4][3] = '{
		'{ 2'sd1,  2'sd1,  2'sd1},  // up
		'{-2'sd1, -2'sd1, -2'sd1},  // down
		'{ 2'sd0, -2'sd1,  2'sd1},  // left
		'{ 2'sd0, -2'sd1,  2'sd1}   // right
	};

endpackage

`default_nettype wire

// File: draw_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module draw_sequencer
	import arrow_pkg::*;
#(
	parameter int pixel_period = 3125000
)
(
	input  wire     clk,
	input  wire     reset_n,
	input  wire     start,
	output logic    ready,
	output logic    busy,
	output logic    done,
	output logic    step_valid,
	output stroke_t stroke,
	output step_t   step
);

	// pacing counter sized for the pixel period
	localparam int pace_w = (pixel_period > 1) ? $clog2(pixel_period) : 1;

	typedef logic [pace_w-1:0] pace_t;

	localparam pace_t pace_last = pace_t'(pixel_period - 1);

	typedef enum logic [1:0]
	{
		idle,
		draw,
		finish
	} state_t;

	state_t state;
	state_t state_next;
	pace_t  pace_cnt;
	logic   stroke_end;   // current step is the last of its stroke
	logic   glyph_end;    // current step is the last of the glyph

	// shaft is longer than the two head strokes
	function automatic step_t last_step(stroke_t s);
		if (s == 2'd0)
			return step_t'(shaft_len - 1);
		else
			return step_t'(head_len - 1);
	endfunction

	assign stroke_end = (step == last_step(stroke));
	assign glyph_end  = stroke_end && (stroke == last_stroke);

	// one step per wrap of the pacing counter
	assign step_valid = (state == draw) && (pace_cnt == pace_last);

	always_comb
	begin
		state_next = state;
		case (state)
			idle:
			begin
				if (start)
					state_next = draw;
			end
			draw:
			begin
				if (step_valid && glyph_end)
					state_next = finish;
			end
			finish:
			begin
				state_next = idle;  // done lasts one cycle
			end
			default:
			begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			state <= idle;
		else
			state <= state_next;
	end

	// counts only while drawing, restarts from zero on every glyph
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			pace_cnt <= '0;
		else if (state != draw)
			pace_cnt <= '0;
		else if (pace_cnt == pace_last)
			pace_cnt <= '0;
		else
			pace_cnt <= pace_cnt + pace_t'(1);
	end

	// stroke and step advance after each emitted step
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			stroke <= '0;
			step   <= '0;
		end
		else if (state != draw)
		begin
			stroke <= '0;
			step   <= '0;
		end
		else if (step_valid)
		begin
			if (!stroke_end)
				step <= step + step_t'(1);
			else if (!glyph_end)
			begin
				step   <= '0;
				stroke <= stroke + stroke_t'(1);
			end
		end
	end

	// a new start is taken as soon as drawing stops
	assign ready = (state != draw);
	assign busy  = (state == draw);
	assign done  = (state == finish);

endmodule

`default_nettype wire

// File: glyph_picker.sv
`timescale 1ns/100ps
`default_nettype none

module glyph_picker
	import arrow_pkg::*;
(
	input  wire     clk,
	input  wire     reset_n,
	input  wire     request,
	input  wire     clear,
	input  wire     ready,
	output logic    start,
	output glyph_t  glyph,
	output colour_t colour
);

	lfsr_t   lfsr;
	logic    request_q;    // request level at the previous edge
	logic    accept;
	glyph_t  glyph_pick;
	colour_t colour_pick;

	// split of the 16 lfsr values over the four glyphs
	function automatic glyph_t pick_glyph(lfsr_t r);
		if (r < 4'd3)
			return glyph_up;
		else if (r < 4'd6)
			return glyph_down;
		else if (r < 4'd9)
			return glyph_left;
		else
			return glyph_right;
	endfunction

	function automatic colour_t glyph_colour(glyph_t g);
		case (g)
			glyph_up:    return 3'd1;
			glyph_down:  return 3'd2;
			glyph_right: return 3'd3;
			default:     return 3'd4;  // left
		endcase
	endfunction

	// free running, steps on every clock once out of reset
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			lfsr <= lfsr_seed;
		else
			lfsr <= {lfsr[2:0], lfsr[2] ^ lfsr[3]};
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			request_q <= 1'b0;
		else
			request_q <= request;
	end

	// rising edge of request, dropped while the sequencer draws
	assign accept = request && !request_q && ready;

	assign glyph_pick  = pick_glyph(lfsr);
	assign colour_pick = clear ? 3'd0 : glyph_colour(glyph_pick);  // clear erases in black

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			start <= 1'b0;
		else
			start <= accept;  // one cycle pulse
	end

	// held until the next accepted request
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			glyph  <= glyph_pick;
			colour <= colour_pick;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
arrow_pkg.sv
glyph_picker.sv
draw_sequencer.sv
stroke_plotter.sv
arrow_draw_top.sv
arrow_draw_tb.sv

// File: stroke_plotter.sv
`timescale 1ns/100ps
`default_nettype none

module stroke_plotter
	import arrow_pkg::*;
(
	input  wire      clk,
	input  wire      reset_n,
	input  wire      step_valid,
	input  wire      stroke_t stroke,
	input  wire      step_t step,
	input  wire      glyph_t glyph,
	input  wire      colour_t colour_in,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t  colour,
	output logic     plot
);

	dir_t     dx;
	dir_t     dy;
	coord_x_t x_next;
	coord_y_t y_next;

	// direction of the current stroke
	always_comb
	begin
		dx = dir_x[glyph][stroke];
		dy = dir_y[glyph][stroke];
	end

	// origin plus step times vector, vector entries are unit or zero
	always_comb
	begin
		case (dx)
			2'sd1:
				x_next = origin_x + coord_x_t'(step);
			-2'sd1:
				x_next = origin_x - coord_x_t'(step);
			default:
				x_next = origin_x;
		endcase
	end

	always_comb
	begin
		case (dy)
			2'sd1:
				y_next = origin_y + coord_y_t'(step);
			-2'sd1:
				y_next = origin_y - coord_y_t'(step);
			default:
				y_next = origin_y;
		endcase
	end

	// pixel register, loaded once per step
	always_ff @(posedge clk)
	begin
		if (step_valid)
		begin
			x      <= x_next;
			y      <= y_next;
			colour <= colour_in;
		end
	end

	// strobe lines up with the registered pixel
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			plot <= 1'b0;
		else
			plot <= step_valid;
	end

endmodule

`default_nettype wire
